/* rob_core.f */
common/rob_pkg.sv
hdl/register_map.sv
rob/reorder_buffer.sv
hdl/rob_core.sv
sim/rob_checker.sv
sim/rob_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the retirement core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module rob_core_tb \
    -f rob_core.f \
    -o rob_core_sim

./obj_dir/rob_core_sim | tee sim.log

if grep -q "^test passed$" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi

/* sim/rob_core_tb.sv */
// ----------------------------------------
// Retirement core testbench
// Random dispatch and bus traffic in six tests
// ----------------------------------------
`default_nettype none

module rob_core_tb;
    import rob_pkg::*;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 8;
    localparam int LANES = 2;
    localparam int HALF = 50;
    // Instruction counts of the six tests, 20 cycles allowed for each
    localparam int LIMIT = (300 + 300 + 12 + 60 + 80 + 80) * 20;

    logic clk, n_rst;
    dispatch_t disp;
    cdb_t cdb [0:LANES-1];
    logic lsu_stall, lsu_mis;
    logic [TAG_W-1:0] tag, lsu_tag;
    operand_t src [0:1];
    retire_t retire;
    logic stall, redirect, lq_en, sq_en;
    logic [ADDR_W-1:0] redirect_addr;
    int test_id, errors, checks, cycles;

    // Stimulus bookkeeping, entries still waiting for a bus result
    bit pend [0:DEPTH-1];
    rob_op_t op_of [0:DEPTH-1];
    int outstanding;
    int p_en, p_rdy, p_cdb, p_redir, p_stall, p_mis, reg_range, op_mode;

    rob_core #(.ROB_DEPTH(DEPTH), .CDB_DEPTH(LANES)) dut0 (
        .clk(clk), .n_rst(n_rst), .i_dispatch(disp), .o_tag(tag), .o_src(src),
        .o_stall(stall), .i_cdb(cdb), .o_retire(retire), .o_redirect(redirect),
        .o_redirect_addr(redirect_addr), .i_lsu_retire_stall(lsu_stall),
        .i_lsu_retire_mis_speculated(lsu_mis), .o_lsu_retire_lq_en(lq_en),
        .o_lsu_retire_sq_en(sq_en), .o_lsu_retire_tag(lsu_tag)
    );

    rob_checker #(.ROB_DEPTH(DEPTH), .CDB_DEPTH(LANES)) chk0 (
        .clk(clk), .n_rst(n_rst), .i_dispatch(disp), .i_cdb(cdb),
        .i_lsu_retire_stall(lsu_stall), .i_lsu_retire_mis_speculated(lsu_mis),
        .i_tag(tag), .i_src(src), .i_stall(stall), .i_retire(retire),
        .i_redirect(redirect), .i_redirect_addr(redirect_addr), .i_lq_en(lq_en),
        .i_sq_en(sq_en), .i_lsu_tag(lsu_tag), .i_test_id(test_id),
        .o_errors(errors), .o_checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic bit chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic rob_op_t pick_op();
        rob_op_t heavy;
        heavy = rob_op_t'(op_mode - 1);
        if (op_mode == 1) return ROB_OP_INT;
        if (op_mode > 1 && chance(50)) return heavy;
        return rob_op_t'($urandom % 4);
    endfunction

    task automatic set_config(input int en, rdy, cd, rd, st, mis, rr, om);
        {p_en, p_rdy, p_cdb, p_redir} = {en, rdy, cd, rd};
        {p_stall, p_mis, reg_range, op_mode} = {st, mis, rr, om};
    endtask

    // One cycle of stimulus, driven at the falling edge and sampled before the rising one
    task automatic drive_cycle(input bit allow_dispatch, inout int pc);
        bit used [0:DEPTH-1];
        bit found;
        int start, t;
        disp = '0;
        if (allow_dispatch && chance(p_en)) begin
            disp.en = 1'b1;
            disp.rdy = chance(p_rdy);
            disp.op = pick_op();
            disp.iaddr = pc;
            disp.addr = $urandom;
            disp.data = $urandom;
            disp.rdest = REG_W'($urandom % reg_range);
            disp.rsrc0 = REG_W'($urandom % reg_range);
            disp.rsrc1 = REG_W'($urandom % reg_range);
            pc += 4;
        end
        for (int l = 0; l < LANES; l++) begin
            cdb[l] = '0;
            found = 1'b0;
            start = $urandom % DEPTH;
            if (chance(p_cdb)) begin
                for (int k = 0; k < DEPTH; k++) begin
                    t = (start + k) % DEPTH;
                    if (!found && pend[t] && !used[t]) begin
                        found = 1'b1;
                        used[t] = 1'b1;
                        pend[t] = 1'b0;
                        cdb[l] = '{en: 1'b1, redirect: (op_of[t] == ROB_OP_BR) && chance(p_redir),
                                   data: $urandom, addr: $urandom, tag: TAG_W'(t)};
                    end
                end
            end
        end
        lsu_stall = chance(p_stall);
        lsu_mis = chance(p_mis);
        #(HALF - 10);
        if (retire.en) outstanding--;
        if (disp.en && !stall && !redirect) begin
            outstanding++;
            op_of[tag % DEPTH] = disp.op;
            pend[tag % DEPTH] = !disp.rdy;
        end
        if (redirect) begin
            outstanding = 0;
            for (int i = 0; i < DEPTH; i++) pend[i] = 1'b0;
        end
        @(negedge clk);
    endtask

    // Offers n instructions, then lets the buffer drain
    task automatic run_test(input int id, input int n);
        int pc, offered;
        test_id = id;
        pc = id * 32'h1000;
        offered = 0;
        while (offered < n) begin
            drive_cycle(1'b1, pc);
            if (disp.en) offered++;
        end
        p_cdb = 60;
        while (outstanding > 0) drive_cycle(1'b0, pc);
        drive_cycle(1'b0, pc);
        drive_cycle(1'b0, pc);
    endtask

    initial begin
        void'($urandom(32'h54f7));
        n_rst = 1'b0;
        disp = '0;
        cdb = '{default: '0};
        lsu_stall = 1'b0;
        lsu_mis = 1'b0;
        test_id = 0;
        outstanding = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        set_config(70, 15, 50, 0, 20, 0, 32, 0);
        run_test(1, 300);
        set_config(80, 30, 60, 0, 10, 0, 4, 1);
        run_test(2, 300);
        set_config(100, 0, 0, 0, 0, 0, 32, 1);
        run_test(3, 12);
        set_config(70, 10, 50, 0, 60, 0, 8, 4);
        run_test(4, 60);
        set_config(70, 10, 50, 40, 10, 0, 8, 2);
        run_test(5, 80);
        set_config(70, 10, 50, 0, 20, 30, 8, 3);
        run_test(6, 80);
        test_id = 0;
        @(negedge clk);
        @(negedge clk);
        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/rob_checker.sv */
// ----------------------------------------
// Retirement checker
// Cycle model of buffer and register map,
// compares every DUT output at each edge
// ----------------------------------------
`default_nettype none

module rob_checker import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int CDB_DEPTH = 2
) (
    input  wire               clk,
    input  wire               n_rst,
    input  wire dispatch_t    i_dispatch,
    input  wire cdb_t         i_cdb [0:CDB_DEPTH-1],
    input  wire               i_lsu_retire_stall,
    input  wire               i_lsu_retire_mis_speculated,
    input  wire [TAG_W-1:0]   i_tag,
    input  wire operand_t     i_src [0:1],
    input  wire               i_stall,
    input  wire retire_t      i_retire,
    input  wire               i_redirect,
    input  wire [ADDR_W-1:0]  i_redirect_addr,
    input  wire               i_lq_en,
    input  wire               i_sq_en,
    input  wire [TAG_W-1:0]   i_lsu_tag,
    input  int                i_test_id,
    output int                o_errors,
    output int                o_checks
);
    timeunit 1ns;
    timeprecision 100ps;

    // Model of the buffer entries, indexed by tag
    logic              m_rdy   [0:ROB_DEPTH-1];
    logic              m_redir [0:ROB_DEPTH-1];
    rob_op_t           m_op    [0:ROB_DEPTH-1];
    logic [ADDR_W-1:0] m_iaddr [0:ROB_DEPTH-1];
    logic [ADDR_W-1:0] m_addr  [0:ROB_DEPTH-1];
    logic [DATA_W-1:0] m_data  [0:ROB_DEPTH-1];
    logic [REG_W-1:0]  m_rdest [0:ROB_DEPTH-1];
    int                m_head;
    int                m_count;

    // Model of the register map
    logic [DATA_W-1:0] r_val [0:31];
    logic [TAG_W-1:0]  r_tag [0:31];
    logic              r_rdy [0:31];

    // Statistics of the running test
    int cur_test = 0;
    int t_errors, t_checks, t_retired, t_redirects, t_stalls, t_sq_holds;
    int t_cdb_fwd, t_rob_fwd;

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    task automatic check_val(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        o_checks++;
        t_checks++;
        if (got !== exp) begin
            o_errors++;
            t_errors++;
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic missed(input string what);
        o_errors++;
        t_errors++;
        $display("test %0d never reached %s", cur_test, what);
    endtask

    // Each test must actually reach the situation it is named after
    task automatic report_test();
        string name;
        case (cur_test)
            1: name = "in-order retirement";
            2: name = "operand resolution";
            3: name = "full buffer";
            4: name = "store back-pressure";
            5: name = "branch redirect and flush";
            default: name = "load mis-speculation";
        endcase
        if (cur_test == 1 && t_retired == 0) missed("a retirement");
        if (cur_test == 2 && t_cdb_fwd == 0) missed("an operand taken from a bus lane");
        if (cur_test == 2 && t_rob_fwd == 0) missed("an operand taken from the buffer");
        if (cur_test == 3 && t_stalls == 0) missed("a full buffer");
        if (cur_test == 4 && t_sq_holds == 0) missed("a held store");
        if (cur_test >= 5 && t_redirects == 0) missed("a redirect");
        $display("test %0d %s: %0d checks, %0d errors, %0d retired, %0d redirects",
                 cur_test, name, t_checks, t_errors, t_retired, t_redirects);
    endtask

    always @(posedge clk) begin : step
        int tail, h, t, r;
        logic full, accept, hr, e_ret, e_redir, e_lq, e_sq, ren, e_rdy;
        logic [DATA_W-1:0] e_data;
        logic [REG_W-1:0] rd;
        rob_op_t hop;

        if (i_test_id != cur_test) begin
            if (cur_test != 0) report_test();
            cur_test = i_test_id;
            {t_errors, t_checks, t_retired, t_redirects, t_stalls, t_sq_holds} = '0;
            t_cdb_fwd = 0;
            t_rob_fwd = 0;
        end

        if (!n_rst) begin
            m_head = 0;
            m_count = 0;
            for (int i = 0; i < ROB_DEPTH; i++) m_rdy[i] = 1'b0;
            for (int i = 0; i < 32; i++) begin
                r_val[i] = '0;
                r_rdy[i] = 1'b1;
            end
            check_val("o_stall", i_stall, 0);
            check_val("o_retire.en", i_retire.en, 0);
            check_val("o_redirect", i_redirect, 0);
            check_val("o_lsu_retire_lq_en", i_lq_en, 0);
            check_val("o_lsu_retire_sq_en", i_sq_en, 0);
        end else begin
            tail = (m_head + m_count) % ROB_DEPTH;
            full = (m_count == ROB_DEPTH);
            accept = i_dispatch.en && !full;
            check_val("o_stall", i_stall, full);
            check_val("o_tag", i_tag, tail);

            // Register value first, then a bus lane, then the buffer entry
            for (int s = 0; s < 2; s++) begin
                r = (s == 0) ? i_dispatch.rsrc0 : i_dispatch.rsrc1;
                if (r == 0) begin
                    e_rdy = 1'b1;
                    e_data = '0;
                end else if (r_rdy[r]) begin
                    e_rdy = 1'b1;
                    e_data = r_val[r];
                end else begin
                    t = r_tag[r] % ROB_DEPTH;
                    e_rdy = m_rdy[t];
                    e_data = m_data[t];
                    if (m_rdy[t]) t_rob_fwd++;
                    for (int j = 0; j < CDB_DEPTH; j++) begin
                        if (i_cdb[j].en && i_cdb[j].tag == r_tag[r]) begin
                            e_rdy = 1'b1;
                            e_data = i_cdb[j].data;
                            t_cdb_fwd++;
                        end
                    end
                    check_val($sformatf("o_src[%0d].tag", s), i_src[s].tag, r_tag[r]);
                end
                check_val($sformatf("o_src[%0d].rdy", s), i_src[s].rdy, e_rdy);
                if (e_rdy) check_val($sformatf("o_src[%0d].data", s), i_src[s].data, e_data);
            end

            // Head of the buffer
            h = m_head;
            hop = m_op[h];
            hr = (m_count > 0) && m_rdy[h];
            e_lq = hr && (hop == ROB_OP_LD);
            e_sq = hr && (hop == ROB_OP_ST);
            e_ret = hr && !(i_lsu_retire_stall && hop == ROB_OP_ST);
            e_redir = e_ret && (m_redir[h] || (i_lsu_retire_mis_speculated && hop == ROB_OP_LD));
            rd = m_rdest[h];
            check_val("o_retire.en", i_retire.en, e_ret);
            check_val("o_redirect", i_redirect, e_redir);
            check_val("o_lsu_retire_lq_en", i_lq_en, e_lq);
            check_val("o_lsu_retire_sq_en", i_sq_en, e_sq);
            if (e_ret) begin
                check_val("o_retire.rdest", i_retire.rdest, rd);
                check_val("o_retire.tag", i_retire.tag, h);
                check_val("o_retire.data", i_retire.data, m_data[h]);
                t_retired++;
            end
            if (e_redir) begin
                check_val("o_redirect_addr", i_redirect_addr,
                          (hop == ROB_OP_BR) ? m_addr[h] : m_iaddr[h]);
                t_redirects++;
            end
            if (e_lq || e_sq) check_val("o_lsu_retire_tag", i_lsu_tag, h);
            if (full) t_stalls++;
            if (e_sq && !e_ret) t_sq_holds++;

            // Register map update, a retire commits even when it redirects
            ren = accept && !e_redir && (i_dispatch.rdest != 0);
            if (e_ret && rd != 0) r_val[rd] = m_data[h];
            if (e_redir) begin
                for (int i = 0; i < 32; i++) r_rdy[i] = 1'b1;
            end else begin
                if (e_ret && rd != 0 && r_tag[rd] == h && !(ren && i_dispatch.rdest == rd))
                    r_rdy[rd] = 1'b1;
                if (ren) begin
                    r_rdy[i_dispatch.rdest] = 1'b0;
                    r_tag[i_dispatch.rdest] = TAG_W'(tail);
                end
            end

            // Buffer update
            if (e_redir) begin
                m_head = 0;
                m_count = 0;
                for (int i = 0; i < ROB_DEPTH; i++) m_rdy[i] = 1'b0;
            end else begin
                for (int j = 0; j < CDB_DEPTH; j++) begin
                    if (i_cdb[j].en) begin
                        t = i_cdb[j].tag % ROB_DEPTH;
                        m_rdy[t] = 1'b1;
                        m_data[t] = i_cdb[j].data;
                        m_addr[t] = i_cdb[j].addr;
                        m_redir[t] = i_cdb[j].redirect;
                    end
                end
                if (accept) begin
                    m_rdy[tail] = i_dispatch.rdy;
                    m_redir[tail] = 1'b0;
                    m_op[tail] = i_dispatch.op;
                    m_iaddr[tail] = i_dispatch.iaddr;
                    m_addr[tail] = i_dispatch.addr;
                    m_data[tail] = i_dispatch.data;
                    m_rdest[tail] = i_dispatch.rdest;
                    m_count++;
                end
                if (e_ret) begin
                    m_head = (h + 1) % ROB_DEPTH;
                    m_count--;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rob_core.sv */
// ----------------------------------------
// Retirement core
// Joins the reorder buffer and register map
// ----------------------------------------
`default_nettype none

module rob_core import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int CDB_DEPTH = 2
) (
    input  wire                   clk,
    input  wire                   n_rst,

    // Dispatch
    input  wire dispatch_t        i_dispatch,
    output logic [TAG_W-1:0]      o_tag,
    output operand_t              o_src [0:1],
    output logic                  o_stall,

    // Common data bus
    input  wire cdb_t             i_cdb [0:CDB_DEPTH-1],

    // Retirement and fetch redirect
    output retire_t               o_retire,
    output logic                  o_redirect,
    output logic [ADDR_W-1:0]     o_redirect_addr,

    // Load/store unit
    input  wire                   i_lsu_retire_stall,
    input  wire                   i_lsu_retire_mis_speculated,
    output logic                  o_lsu_retire_lq_en,
    output logic                  o_lsu_retire_sq_en,
    output logic [TAG_W-1:0]      o_lsu_retire_tag
);

    // Buffer to map traffic
    logic [REG_W-1:0] lookup_rsrc [0:1];
    lookup_t          lookup      [0:1];
    logic             rename_en;
    logic [REG_W-1:0] rename_rdest;
    logic [TAG_W-1:0] rename_tag;

    // The retire result and the redirect go out and into the map together
    register_map rmap0 (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_lookup_rsrc  (lookup_rsrc),
        .o_lookup       (lookup),
        .i_rename_en    (rename_en),
        .i_rename_rdest (rename_rdest),
        .i_rename_tag   (rename_tag),
        .i_retire       (o_retire),
        .i_redirect     (o_redirect)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH),
        .CDB_DEPTH (CDB_DEPTH)
    ) rob0 (
        .clk                         (clk),
        .n_rst                       (n_rst),
        .i_dispatch                  (i_dispatch),
        .o_tag                       (o_tag),
        .o_src                       (o_src),
        .o_stall                     (o_stall),
        .i_cdb                       (i_cdb),
        .o_lookup_rsrc               (lookup_rsrc),
        .i_lookup                    (lookup),
        .o_rename_en                 (rename_en),
        .o_rename_rdest              (rename_rdest),
        .o_rename_tag                (rename_tag),
        .o_retire                    (o_retire),
        .o_redirect                  (o_redirect),
        .o_redirect_addr             (o_redirect_addr),
        .i_lsu_retire_stall          (i_lsu_retire_stall),
        .i_lsu_retire_mis_speculated (i_lsu_retire_mis_speculated),
        .o_lsu_retire_lq_en          (o_lsu_retire_lq_en),
        .o_lsu_retire_sq_en          (o_lsu_retire_sq_en),
        .o_lsu_retire_tag            (o_lsu_retire_tag)
    );

endmodule

`default_nettype wire

/* rob/reorder_buffer.sv */
// ----------------------------------------
// Reorder buffer
// Queues dispatched instructions, collects bus
// results and retires them in program order
// ----------------------------------------
`default_nettype none

module reorder_buffer import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int CDB_DEPTH = 2
) (
    input  wire                   clk,
    input  wire                   n_rst,

    // Dispatch side
    input  wire dispatch_t        i_dispatch,
    output logic [TAG_W-1:0]      o_tag,
    output operand_t              o_src [0:1],
    output logic                  o_stall,

    // Common data bus lanes
    input  wire cdb_t             i_cdb [0:CDB_DEPTH-1],

    // Register map lookup, rename and retire traffic
    output logic [REG_W-1:0]      o_lookup_rsrc [0:1],
    input  wire lookup_t          i_lookup [0:1],
    output logic                  o_rename_en,
    output logic [REG_W-1:0]      o_rename_rdest,
    output logic [TAG_W-1:0]      o_rename_tag,
    output retire_t               o_retire,

    // Fetch redirect
    output logic                  o_redirect,
    output logic [ADDR_W-1:0]     o_redirect_addr,

    // Load/store unit retirement
    input  wire                   i_lsu_retire_stall,
    input  wire                   i_lsu_retire_mis_speculated,
    output logic                  o_lsu_retire_lq_en,
    output logic                  o_lsu_retire_sq_en,
    output logic [TAG_W-1:0]      o_lsu_retire_tag
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    // Payload of one entry, the ready bit is kept in its own vector
    typedef struct packed {
        logic              redirect;
        rob_op_t           op;
        logic [ADDR_W-1:0] iaddr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [REG_W-1:0]  rdest;
    } rob_entry_t;

    rob_entry_t           ent_q [0:ROB_DEPTH-1];
    logic [ROB_DEPTH-1:0] rdy_q;

    // Pointers carry one wrap bit above the index
    logic [IDX_W:0]       head_q;
    logic [IDX_W:0]       tail_q;
    logic [IDX_W-1:0]     head_idx;
    logic [IDX_W-1:0]     tail_idx;
    logic                 full;
    logic                 empty;

    rob_entry_t           head;
    logic                 dispatch_en;
    logic                 retire_rdy;
    logic                 retire_en;
    logic                 st_stall;
    logic                 ld_mis_spec;
    logic                 redirect;
    logic [IDX_W-1:0]     cdb_idx [0:CDB_DEPTH-1];
    logic [IDX_W-1:0]     src_idx [0:1];

    assign head_idx = head_q[IDX_W-1:0];
    assign tail_idx = tail_q[IDX_W-1:0];

    // Full when the indices meet but the wrap bits differ
    assign full     = (tail_q == {~head_q[IDX_W], head_q[IDX_W-1:0]});
    assign empty    = (tail_q == head_q);
    assign head     = ent_q[head_idx];

    assign dispatch_en = i_dispatch.en && !full;

    // A store waits at the head while the load/store unit holds it back
    assign st_stall    = i_lsu_retire_stall && (head.op == ROB_OP_ST);
    assign retire_rdy  = rdy_q[head_idx] && !empty;
    assign retire_en   = retire_rdy && !st_stall;

    // A load only redirects on mis-speculation once it reaches the head
    assign ld_mis_spec = i_lsu_retire_mis_speculated && (head.op == ROB_OP_LD);
    assign redirect    = retire_en && (head.redirect || ld_mis_spec);

    assign o_redirect      = redirect;
    assign o_redirect_addr = (head.op == ROB_OP_BR) ? head.addr : head.iaddr;

    assign o_stall = full;
    assign o_tag   = TAG_W'(tail_idx);

    // Register 0 is hardwired so it never gets a rename
    assign o_rename_en    = dispatch_en && !redirect && (i_dispatch.rdest != '0);
    assign o_rename_rdest = i_dispatch.rdest;
    assign o_rename_tag   = TAG_W'(tail_idx);

    assign o_retire.en    = retire_en;
    assign o_retire.rdest = head.rdest;
    assign o_retire.tag   = TAG_W'(head_idx);
    assign o_retire.data  = head.data;

    // Loads and stores are announced as soon as they are ready at the head
    assign o_lsu_retire_lq_en = retire_rdy && (head.op == ROB_OP_LD);
    assign o_lsu_retire_sq_en = retire_rdy && (head.op == ROB_OP_ST);
    assign o_lsu_retire_tag   = TAG_W'(head_idx);

    assign o_lookup_rsrc[0] = i_dispatch.rsrc0;
    assign o_lookup_rsrc[1] = i_dispatch.rsrc1;

    // Mapped tags and bus tags index the entry array directly
    assign src_idx[0] = i_lookup[0].tag[IDX_W-1:0];
    assign src_idx[1] = i_lookup[1].tag[IDX_W-1:0];

    for (genvar j = 0; j < CDB_DEPTH; j++) begin : g_cdb_idx
        assign cdb_idx[j] = i_cdb[j].tag[IDX_W-1:0];
    end

    // Operand resolution
    // A committed register value wins, then a bus result in flight this cycle,
    // then whatever the buffer entry behind the mapped tag holds
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (i_lookup[i].rdy) begin
                o_src[i] = '{rdy: 1'b1, tag: i_lookup[i].tag, data: i_lookup[i].data};
            end else begin
                o_src[i] = '{rdy: rdy_q[src_idx[i]], tag: i_lookup[i].tag,
                             data: ent_q[src_idx[i]].data};
                for (int j = 0; j < CDB_DEPTH; j++) begin
                    if (i_cdb[j].en && (i_cdb[j].tag == i_lookup[i].tag)) begin
                        o_src[i] = '{rdy: 1'b1, tag: i_lookup[i].tag, data: i_cdb[j].data};
                    end
                end
            end
        end
    end

    // Entry payload is written by dispatch at the tail or by a bus lane at its tag
    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (dispatch_en && (tail_idx == IDX_W'(i))) begin
                ent_q[i] <= '{redirect: 1'b0, op: i_dispatch.op, iaddr: i_dispatch.iaddr,
                              addr: i_dispatch.addr, data: i_dispatch.data,
                              rdest: i_dispatch.rdest};
            end else begin
                for (int j = 0; j < CDB_DEPTH; j++) begin
                    if (i_cdb[j].en && (cdb_idx[j] == IDX_W'(i))) begin
                        ent_q[i].redirect <= i_cdb[j].redirect;
                        ent_q[i].addr     <= i_cdb[j].addr;
                        ent_q[i].data     <= i_cdb[j].data;
                    end
                end
            end
        end
    end

    // Ready bits, all cleared by a flush
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '0;
        end else if (redirect) begin
            rdy_q <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (dispatch_en && (tail_idx == IDX_W'(i))) begin
                    rdy_q[i] <= i_dispatch.rdy;
                end else begin
                    for (int j = 0; j < CDB_DEPTH; j++) begin
                        if (i_cdb[j].en && (cdb_idx[j] == IDX_W'(i))) begin
                            rdy_q[i] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Both pointers go back to zero on a redirect
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (redirect) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (dispatch_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_en) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // The occupancy never exceeds the depth
    // A dispatch into a full buffer or a retire from an empty one would break it
    a_occupancy: assert property (@(posedge clk) disable iff (!n_rst)
        (IDX_W+1)'(tail_q - head_q) <= (IDX_W+1)'(ROB_DEPTH));

    // Two lanes never write the same entry in one cycle
    for (genvar j = 0; j < CDB_DEPTH; j++) begin : g_cdb_chk
        for (genvar k = j + 1; k < CDB_DEPTH; k++) begin : g_pair
            a_cdb_tag_unique: assert property (@(posedge clk) disable iff (!n_rst)
                !(i_cdb[j].en && i_cdb[k].en && (i_cdb[j].tag == i_cdb[k].tag)));
        end
    end

endmodule

`default_nettype wire

/* hdl/register_map.sv */
// ----------------------------------------
// Register map
// Committed values and rename tags for the
// architectural registers, with two lookups
// ----------------------------------------
`default_nettype none

module register_map import rob_pkg::*; (
    input  wire                   clk,
    input  wire                   n_rst,

    // Source register lookups for the instruction being dispatched
    input  wire [REG_W-1:0]       i_lookup_rsrc [0:1],
    output lookup_t               o_lookup [0:1],

    // Rename of the destination register to a buffer tag
    input  wire                   i_rename_en,
    input  wire [REG_W-1:0]       i_rename_rdest,
    input  wire [TAG_W-1:0]       i_rename_tag,

    // Commit of the retiring result
    input  wire retire_t          i_retire,

    // Flush of all rename state
    input  wire                   i_redirect
);

    localparam int NUM_REGS = 2 ** REG_W;

    logic [DATA_W-1:0]   value_q [0:NUM_REGS-1];
    logic [TAG_W-1:0]    tag_q   [0:NUM_REGS-1];
    logic [NUM_REGS-1:0] rdy_q;

    logic                retire_wr;
    logic                retire_set;
    logic                same_reg;

    // Writes to register 0 are dropped
    assign retire_wr = i_retire.en && (i_retire.rdest != '0);

    // A rename of the retiring register in this cycle keeps it pending
    assign same_reg   = i_rename_en && (i_rename_rdest == i_retire.rdest);

    // Only the youngest producer may mark the register ready again
    assign retire_set = retire_wr && (tag_q[i_retire.rdest] == i_retire.tag) && !same_reg;

    // Committed architectural values start out as zero
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                value_q[r] <= '0;
            end
        end else if (retire_wr) begin
            value_q[i_retire.rdest] <= i_retire.data;
        end
    end

    // Rename tags only matter while the ready bit is low
    always_ff @(posedge clk) begin
        if (i_rename_en) begin
            tag_q[i_rename_rdest] <= i_rename_tag;
        end
    end

    // A flush makes every register committed and ready
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '1;
        end else if (i_redirect) begin
            rdy_q <= '1;
        end else begin
            if (retire_set) begin
                rdy_q[i_retire.rdest] <= 1'b1;
            end
            // Rename comes last so it overrides a retire of the same register
            if (i_rename_en) begin
                rdy_q[i_rename_rdest] <= 1'b0;
            end
        end
    end

    // Lookups read the table as it stood at the last edge
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (i_lookup_rsrc[i] == '0) begin
                o_lookup[i] = '{rdy: 1'b1, tag: '0, data: '0};
            end else begin
                o_lookup[i] = '{rdy: rdy_q[i_lookup_rsrc[i]], tag: tag_q[i_lookup_rsrc[i]],
                                data: value_q[i_lookup_rsrc[i]]};
            end
        end
    end

    // The buffer filters out renames of the zero register
    a_no_rename_r0: assert property (@(posedge clk) disable iff (!n_rst)
        i_rename_en |-> (i_rename_rdest != '0));

endmodule

`default_nettype wire

/* common/rob_pkg.sv */
// ----------------------------------------
// Retirement package
// Shared widths, the operation encoding and
// the packed structs used by buffer and map
// ----------------------------------------
`default_nettype none

package rob_pkg;

    // Data words and instruction addresses are one machine word wide
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // Thirty-two architectural registers
    localparam int REG_W  = 5;

    // Tags are wide enough for a buffer of up to 16 entries
    localparam int TAG_W  = 4;

    // Kind of instruction held in a buffer entry
    typedef enum logic [1:0] {
        ROB_OP_INT = 2'b00,
        ROB_OP_BR  = 2'b01,
        ROB_OP_LD  = 2'b10,
        ROB_OP_ST  = 2'b11
    } rob_op_t;

    // One instruction offered by the dispatcher
    // The rdy bit marks instructions that need no execution (already complete)
    typedef struct packed {
        logic              en;
        logic              rdy;
        rob_op_t           op;
        logic [ADDR_W-1:0] iaddr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [REG_W-1:0]  rdest;
        logic [REG_W-1:0]  rsrc0;
        logic [REG_W-1:0]  rsrc1;
    } dispatch_t;

    // One common data bus lane
    // The addr field carries the resolved target of a branch
    typedef struct packed {
        logic              en;
        logic              redirect;
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] addr;
        logic [TAG_W-1:0]  tag;
    } cdb_t;

    // A source operand as handed back to the dispatcher
    typedef struct packed {
        logic              rdy;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } operand_t;

    // The result of the instruction leaving the head of the buffer
    typedef struct packed {
        logic              en;
        logic [REG_W-1:0]  rdest;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } retire_t;

    // What the register map knows about one source register
    typedef struct packed {
        logic              rdy;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } lookup_t;

endpackage

`default_nettype wire
